/* build.f */
hdl/wb_bus_pkg.sv
hdl/store_buf_pkg.sv
hdl/wb_if.sv
hdl/wb_merger.sv
hdl/wb_store_buffer.sv
hdl/wb_bus_master.sv
hdl/mem_bus_top.sv
sim/mem_bus_sva.sv
sim/tb_mem_bus.sv

/* Makefile */
# Verilator flow for the memory bus testbench.

VERILATOR ?= verilator
TOP       ?= tb_mem_bus
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_STR  ?= TEST PASS
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_mem_bus.sv */
`timescale 1ns/10ps

module tb_mem_bus;

// --------------------------------------------------
// Run limits and table layout.
// --------------------------------------------------

localparam int         NROWS     = 18;
localparam int         TIMEOUT   = 2000;  // Negedges per wait.
localparam int         SLOW_WAIT = 30;    // Wait states while the buffer fills.
localparam logic [1:0] SRC_C     = 2'd0;  // Code client only.
localparam logic [1:0] SRC_D     = 2'd1;  // Data client only.
localparam logic [1:0] SRC_B     = 2'd2;  // Both, same cycle.

typedef logic [wb_bus_pkg::DATA_W-1:0] word_t;
typedef logic [wb_bus_pkg::ADDR_W-1:0] addr_t;

typedef struct packed {
        logic [1:0]                   src;
        logic                         we;
        addr_t                        adr;   // Code side of a shared row fetches 64 bytes up.
        word_t                        dat;
        logic [wb_bus_pkg::SEL_W-1:0] sel;
        logic                         slow;  // Long external waits.
} row_t;

logic                         i_clk;
logic                         i_rst_n;
logic                         i_c_wb_cyc;
logic                         i_c_wb_stb;
addr_t                        i_c_wb_adr;
logic                         o_c_wb_ack;
word_t                        o_c_wb_dat;
logic                         i_d_wb_cyc;
logic                         i_d_wb_stb;
logic                         i_d_wb_we;
addr_t                        i_d_wb_adr;
word_t                        i_d_wb_dat;
logic [wb_bus_pkg::SEL_W-1:0] i_d_wb_sel;
logic                         o_d_wb_ack;
word_t                        o_d_wb_dat;
logic                         o_wb_cyc;
logic                         o_wb_stb;
logic                         o_wb_we;
addr_t                        o_wb_adr;
word_t                        o_wb_dat;
logic [wb_bus_pkg::SEL_W-1:0] o_wb_sel;
logic                         i_wb_ack;
word_t                        i_wb_dat;

row_t                rows [NROWS];
wb_bus_pkg::wb_req_t exp_log [$];           // Expected external cycles, in order.
wb_bus_pkg::wb_req_t bus_log [$];           // Seen by the bus model.
logic [7:0]          bus_mem [addr_t];      // Bus model bytes.
logic [7:0]          ref_mem [addr_t];      // Reference view, updated at client ack.
logic                slow_mode;
logic                saw_stall;
int                  errors;
int                  timeouts;

mem_bus_top uut (.*);

initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
end

// --------------------------------------------------
// Memory helpers.
// --------------------------------------------------

function automatic logic [7:0] fill_byte(input addr_t a);
        addr_t h;
        h = a * 32'h9e37_79b1;                  // Hash of the whole address.
        return h[31:24];
endfunction

function automatic logic [7:0] bus_byte(input addr_t a);
        return bus_mem.exists(a) ? bus_mem[a] : fill_byte(a);
endfunction

function automatic logic [7:0] ref_byte(input addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
endfunction

// Selected lanes from memory, zero elsewhere.
function automatic word_t expect_word(input addr_t adr, input logic [wb_bus_pkg::SEL_W-1:0] sel);
        word_t w;
        for (int i = 0; i < wb_bus_pkg::SEL_W; i++)
                w[8*i +: 8] = sel[i] ? ref_byte({adr[31:2], 2'b00} + i) : 8'h00;
        return w;
endfunction

function automatic wb_bus_pkg::wb_req_t make_req(input logic we, input addr_t adr,
                                                 input word_t dat,
                                                 input logic [wb_bus_pkg::SEL_W-1:0] sel);
        wb_bus_pkg::wb_req_t r;
        r.we  = we;
        r.adr = adr;
        r.dat = we ? dat : '0;                  // Load data lanes are don't care.
        r.sel = sel;
        return r;
endfunction

// --------------------------------------------------
// Compare tasks.
// --------------------------------------------------

task automatic check_req(input wb_bus_pkg::wb_req_t got, input wb_bus_pkg::wb_req_t exp,
                         input string what);
        if (got !== exp) begin
                errors++;
                $display("ERROR %0t: %s got we=%0b adr=%h dat=%h sel=%h", $time, what,
                         got.we, got.adr, got.dat, got.sel);
                $display("ERROR %0t: %s exp we=%0b adr=%h dat=%h sel=%h", $time, what,
                         exp.we, exp.adr, exp.dat, exp.sel);
        end
endtask

task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
                errors++;
                $display("ERROR %0t: %s got %h, expected %h", $time, what, got, exp);
        end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
                errors++;
                $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
endtask

task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
                errors++;
                $display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
endtask

// --------------------------------------------------
// Bus model. Acks after 0 to 3 waits, or SLOW_WAIT.
// --------------------------------------------------

initial begin : bus_model
        int    wait_left;
        addr_t base;
        word_t rd;
        wait_left = -1;
        forever begin
                @(negedge i_clk);
                if (i_wb_ack) begin
                        i_wb_ack = 1'b0;        // Master drops cyc on this edge.
                end else if (o_wb_cyc && o_wb_stb) begin
                        if (wait_left < 0)
                                wait_left = slow_mode ? SLOW_WAIT : int'($urandom_range(3, 0));
                        if (wait_left == 0) begin
                                base = {o_wb_adr[31:2], 2'b00};
                                for (int i = 0; i < wb_bus_pkg::SEL_W; i++) begin
                                        if (o_wb_we && o_wb_sel[i])
                                                bus_mem[base + i] = o_wb_dat[8*i +: 8];
                                        rd[8*i +: 8] = o_wb_sel[i] ? bus_byte(base + i) : 8'h00;
                                end
                                bus_log.push_back(make_req(o_wb_we, o_wb_adr, o_wb_dat, o_wb_sel));
                                i_wb_dat  = rd;
                                i_wb_ack  = 1'b1;
                                wait_left = -1;
                        end else begin
                                wait_left--;
                        end
                end
        end
end

// --------------------------------------------------
// Stimulus table.
// --------------------------------------------------

task automatic load_table();
        rows[0]  = '{SRC_D, 1'b1, 32'h0000_0100, 32'h1122_3344, 4'hf, 1'b0};
        rows[1]  = '{SRC_D, 1'b1, 32'h0000_0104, 32'ha5a5_a5a5, 4'h3, 1'b0};
        rows[2]  = '{SRC_D, 1'b1, 32'h0000_0100, 32'hdead_beef, 4'h6, 1'b0};
        rows[3]  = '{SRC_D, 1'b0, 32'h0000_0100, 32'h0,         4'hf, 1'b0};
        rows[4]  = '{SRC_D, 1'b0, 32'h0000_0104, 32'h0,         4'hc, 1'b0};
        rows[5]  = '{SRC_C, 1'b0, 32'h0000_0102, 32'h0,         4'hf, 1'b0};
        rows[6]  = '{SRC_C, 1'b0, 32'h0000_0200, 32'h0,         4'hf, 1'b0};
        for (int k = 0; k < 7; k++)             // Enough to fill the buffer.
                rows[7+k] = '{SRC_D, 1'b1, 32'h300 + 32'(4*k), 32'hc0de_0000 + 32'(k),
                              4'hf, 1'b1};
        rows[14] = '{SRC_D, 1'b0, 32'h0000_0318, 32'h0,         4'hf, 1'b0};
        rows[15] = '{SRC_B, 1'b1, 32'h0000_0400, 32'hcafe_f00d, 4'hf, 1'b0};
        rows[16] = '{SRC_B, 1'b0, 32'h0000_0104, 32'h0,         4'hf, 1'b0};
        rows[17] = '{SRC_D, 1'b0, 32'h0000_0400, 32'h0,         4'hf, 1'b0};
endtask

// One row. Per client state is 0 idle, 1 waiting, 2 acked.
task automatic run_row(input row_t r, input int idx);
        int    n;
        int    d_st;
        int    c_st;
        addr_t c_adr;
        n         = 0;
        d_st      = (r.src != SRC_C) ? 1 : 0;
        c_st      = (r.src != SRC_D) ? 1 : 0;
        c_adr     = (r.src == SRC_B) ? r.adr + 32'h40 : r.adr;
        slow_mode = r.slow;
        @(negedge i_clk);                       // Idle cycle, merger lets go.
        if (d_st == 1) begin
                i_d_wb_cyc = 1'b1;
                i_d_wb_stb = 1'b1;
                i_d_wb_we  = r.we;
                i_d_wb_adr = r.adr;
                i_d_wb_dat = r.dat;
                i_d_wb_sel = r.sel;
                exp_log.push_back(make_req(r.we, r.adr, r.dat, r.sel));
        end
        if (c_st == 1) begin
                i_c_wb_cyc = 1'b1;
                i_c_wb_stb = 1'b1;
                i_c_wb_adr = c_adr;
                exp_log.push_back(make_req(1'b0, {c_adr[31:2], 2'b00}, '0, '1));
        end
        while ((d_st != 0 || c_st != 0) && n < TIMEOUT) begin
                @(negedge i_clk);
                n++;
                if (d_st == 2) begin            // Ack taken on the last edge.
                        d_st       = 0;
                        i_d_wb_cyc = 1'b0;
                        i_d_wb_stb = 1'b0;
                end
                if (c_st == 2) begin
                        c_st       = 0;
                        i_c_wb_cyc = 1'b0;
                        i_c_wb_stb = 1'b0;
                end
                if (d_st == 1 && o_d_wb_ack) begin
                        d_st = 2;
                        if (r.we) begin
                                for (int i = 0; i < wb_bus_pkg::SEL_W; i++)
                                        if (r.sel[i])
                                                ref_mem[{r.adr[31:2], 2'b00} + i] = r.dat[8*i +: 8];
                        end else begin
                                check_word(o_d_wb_dat, expect_word(r.adr, r.sel), "data load");
                        end
                        if (r.slow && n > 6) begin
                                saw_stall = 1'b1; // Held off by a full buffer.
                                // Acked stores not yet seen on the bus, one of them in flight.
                                check_count(exp_log.size() - 1 - bus_log.size(),
                                            store_buf_pkg::SB_DEPTH, "stores pending at release");
                        end
                end
                if (c_st == 1 && o_c_wb_ack) begin
                        c_st = 2;
                        check_word(o_c_wb_dat, expect_word(c_adr, '1), "code fetch");
                end
        end
        if (d_st != 0 || c_st != 0) begin
                timeouts++;
                $display("Timeout: row %0d got no ack from the DUT", idx);
        end
endtask

// --------------------------------------------------
// Main sequence.
// --------------------------------------------------

initial begin : main
        int n;
        void'($urandom(32'hf5cbec6d));
        errors     = 0;
        timeouts   = 0;
        saw_stall  = 1'b0;
        slow_mode  = 1'b0;
        i_rst_n    = 1'b0;
        i_c_wb_cyc = 1'b0;
        i_c_wb_stb = 1'b0;
        i_c_wb_adr = '0;
        i_d_wb_cyc = 1'b0;
        i_d_wb_stb = 1'b0;
        i_d_wb_we  = 1'b0;
        i_d_wb_adr = '0;
        i_d_wb_dat = '0;
        i_d_wb_sel = '0;
        i_wb_ack   = 1'b0;
        i_wb_dat   = '0;
        load_table();
        repeat (4) @(negedge i_clk);
        i_rst_n = 1'b1;

        repeat (3) begin                        // Quiet until a client asks.
                @(negedge i_clk);
                check_bit(o_wb_cyc, 1'b0, "o_wb_cyc after reset");
                check_bit(o_wb_stb, 1'b0, "o_wb_stb after reset");
                check_bit(o_c_wb_ack, 1'b0, "o_c_wb_ack after reset");
                check_bit(o_d_wb_ack, 1'b0, "o_d_wb_ack after reset");
        end

        for (int i = 0; i < NROWS && timeouts == 0; i++)
                run_row(rows[i], i);

        n = 0;                                  // Posted stores still draining.
        while (bus_log.size() < exp_log.size() && n < TIMEOUT) begin
                @(negedge i_clk);
                n++;
        end
        if (bus_log.size() != exp_log.size()) begin
                timeouts++;
                $display("Timeout: %0d external cycles seen, %0d expected",
                         bus_log.size(), exp_log.size());
        end else begin
                foreach (exp_log[i])
                        check_req(bus_log[i], exp_log[i], "external cycle");
        end
        check_bit(saw_stall, 1'b1, "data stall on full buffer");

        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
                $display("TEST PASS");
        end else begin
                $display("TEST FAIL");
        end
        $finish;
end

endmodule

/* sim/mem_bus_sva.sv */
`timescale 1ns/10ps

module mem_bus_sva (
        input logic                          i_clk,
        input logic                          i_rst_n,
        input logic                          o_wb_cyc,
        input logic                          o_wb_stb,
        input logic                          o_wb_we,
        input logic [wb_bus_pkg::ADDR_W-1:0] o_wb_adr,
        input logic [wb_bus_pkg::DATA_W-1:0] o_wb_dat,
        input logic [wb_bus_pkg::SEL_W-1:0]  o_wb_sel,
        input logic                          i_wb_ack,
        input logic                          i_d_wb_stb,
        input logic                          o_d_wb_ack
);

// --------------------------------------------------
// External bus.
// --------------------------------------------------

// Classic cycle closes on the clock after ack.
a_cyc_end: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_wb_stb && i_wb_ack) |=> (!o_wb_cyc && !o_wb_stb))
        else $error("o_wb_cyc or o_wb_stb held past ack");

// Payload frozen until the slave acks.
a_req_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_wb_stb && !i_wb_ack) |=> ($stable(o_wb_adr) && $stable(o_wb_we) &&
                                     $stable(o_wb_dat) && $stable(o_wb_sel)))
        else $error("external request changed before ack");

// --------------------------------------------------
// Data client ack.
// --------------------------------------------------

a_d_ack_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_d_wb_ack |-> i_d_wb_stb)
        else $error("o_d_wb_ack without data stb");

a_d_ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_d_wb_ack |=> !o_d_wb_ack)
        else $error("o_d_wb_ack longer than one cycle");

endmodule

bind mem_bus_top mem_bus_sva u_mem_bus_sva (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .o_wb_cyc    (o_wb_cyc),
        .o_wb_stb    (o_wb_stb),
        .o_wb_we     (o_wb_we),
        .o_wb_adr    (o_wb_adr),
        .o_wb_dat    (o_wb_dat),
        .o_wb_sel    (o_wb_sel),
        .i_wb_ack    (i_wb_ack),
        .i_d_wb_stb  (i_d_wb_stb),
        .o_d_wb_ack  (o_d_wb_ack)
);

/* hdl/mem_bus_top.sv */
`timescale 1ns/10ps

module mem_bus_top (
        input  logic                          i_clk,
        input  logic                          i_rst_n,

        // --------------------------------------------------
        // Code client.
        // --------------------------------------------------

        input  logic                          i_c_wb_cyc,
        input  logic                          i_c_wb_stb,
        input  logic [wb_bus_pkg::ADDR_W-1:0] i_c_wb_adr,
        output logic                          o_c_wb_ack,
        output logic [wb_bus_pkg::DATA_W-1:0] o_c_wb_dat,

        // --------------------------------------------------
        // Data client.
        // --------------------------------------------------

        input  logic                          i_d_wb_cyc,
        input  logic                          i_d_wb_stb,
        input  logic                          i_d_wb_we,
        input  logic [wb_bus_pkg::ADDR_W-1:0] i_d_wb_adr,
        input  logic [wb_bus_pkg::DATA_W-1:0] i_d_wb_dat,
        input  logic [wb_bus_pkg::SEL_W-1:0]  i_d_wb_sel,
        output logic                          o_d_wb_ack,
        output logic [wb_bus_pkg::DATA_W-1:0] o_d_wb_dat,

        // --------------------------------------------------
        // External bus.
        // --------------------------------------------------

        output logic                          o_wb_cyc,
        output logic                          o_wb_stb,
        output logic                          o_wb_we,
        output logic [wb_bus_pkg::ADDR_W-1:0] o_wb_adr,
        output logic [wb_bus_pkg::DATA_W-1:0] o_wb_dat,
        output logic [wb_bus_pkg::SEL_W-1:0]  o_wb_sel,
        input  logic                          i_wb_ack,
        input  logic [wb_bus_pkg::DATA_W-1:0] i_wb_dat
);

wb_req_if u_req_if (); // Merged stream.
sb_pop_if u_pop_if (); // Buffer head.

wb_merger u_wb_merger (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_c_wb_cyc  (i_c_wb_cyc),
        .i_c_wb_stb  (i_c_wb_stb),
        .i_c_wb_adr  (i_c_wb_adr),
        .o_c_wb_ack  (o_c_wb_ack),
        .o_c_wb_dat  (o_c_wb_dat),
        .i_d_wb_cyc  (i_d_wb_cyc),
        .i_d_wb_stb  (i_d_wb_stb),
        .i_d_wb_we   (i_d_wb_we),
        .i_d_wb_adr  (i_d_wb_adr),
        .i_d_wb_dat  (i_d_wb_dat),
        .i_d_wb_sel  (i_d_wb_sel),
        .o_d_wb_ack  (o_d_wb_ack),
        .o_d_wb_dat  (o_d_wb_dat),
        .o_req       (u_req_if.master)
);

wb_store_buffer u_wb_store_buffer (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (u_req_if.slave),
        .o_pop       (u_pop_if.source)
);

wb_bus_master u_wb_bus_master (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_pop       (u_pop_if.sink),
        .o_wb_cyc    (o_wb_cyc),
        .o_wb_stb    (o_wb_stb),
        .o_wb_we     (o_wb_we),
        .o_wb_adr    (o_wb_adr),
        .o_wb_dat    (o_wb_dat),
        .o_wb_sel    (o_wb_sel),
        .i_wb_ack    (i_wb_ack),
        .i_wb_dat    (i_wb_dat)
);

endmodule

/* hdl/wb_bus_master.sv */
`timescale 1ns/10ps

module wb_bus_master (
        input  logic                          i_clk,
        input  logic                          i_rst_n,

        // Buffer head.
        sb_pop_if.sink                        i_pop,

        // --------------------------------------------------
        // External Wishbone classic.
        // --------------------------------------------------

        output logic                          o_wb_cyc,
        output logic                          o_wb_stb,
        output logic                          o_wb_we,
        output logic [wb_bus_pkg::ADDR_W-1:0] o_wb_adr,
        output logic [wb_bus_pkg::DATA_W-1:0] o_wb_dat,
        output logic [wb_bus_pkg::SEL_W-1:0]  o_wb_sel,
        input  logic                          i_wb_ack,
        input  logic [wb_bus_pkg::DATA_W-1:0] i_wb_dat
);

logic                          busy;    // Idle when low, busy when high.
logic                          done_q;  // Load finished, one cycle.
logic [wb_bus_pkg::DATA_W-1:0] rdat_q;  // Captured load data.
logic                          fin;     // Cycle ends now.

// Take the head as soon as we are idle.
assign i_pop.pop = ~busy & i_pop.valid;
assign fin       = busy & i_wb_ack;

// State machine.
always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
                busy   <= 1'b0;
                done_q <= 1'b0;
        end else begin
                if (i_pop.pop)
                        busy <= 1'b1;           // Cycle opens next clock.
                else if (fin)
                        busy <= 1'b0;           // Drop after ack.

                done_q <= fin & ~o_wb_we;       // Loads only.
        end
end

// Bus payload, loaded on pop.
always_ff @(posedge i_clk) begin
        if (i_pop.pop) begin
                o_wb_we  <= i_pop.entry.req.we;
                o_wb_adr <= i_pop.entry.req.adr;
                o_wb_dat <= i_pop.entry.req.dat;
                // Code entries always move a full word.
                o_wb_sel <= i_pop.entry.src_d ? i_pop.entry.req.sel : '1;
        end

        if (fin & ~o_wb_we)
                rdat_q <= i_wb_dat;             // Capture on ack.
end

// Classic cycle, cyc and stb together.
assign o_wb_cyc   = busy;
assign o_wb_stb   = busy;

assign i_pop.done = done_q;
assign i_pop.rdat = rdat_q;

endmodule

/* hdl/wb_store_buffer.sv */
`timescale 1ns/10ps

module wb_store_buffer (
        input  logic      i_clk,
        input  logic      i_rst_n,
        wb_req_if.slave   i_req,    // From merger.
        sb_pop_if.source  o_pop     // To bus master.
);

// --------------------------------------------------
// Storage and pointers.
// --------------------------------------------------

store_buf_pkg::sb_entry_t               mem [store_buf_pkg::SB_DEPTH]; // Circular queue.
logic [store_buf_pkg::SB_PTR_W-1:0]     wr_ptr;   // Next free slot.
logic [store_buf_pkg::SB_PTR_W-1:0]     rd_ptr;   // Head.
logic [store_buf_pkg::SB_PTR_W:0]       count;    // Occupancy.

logic                                   ack_q;    // Client ack pulse.
logic                                   rd_pend;  // Load queued, data not back.
logic [wb_bus_pkg::DATA_W-1:0]          rdat_q;   // Load data for the client.

logic                                   full;
logic                                   enq;
logic                                   deq;

// Wrap at the last slot.
function automatic logic [store_buf_pkg::SB_PTR_W-1:0] ptr_inc (
        input logic [store_buf_pkg::SB_PTR_W-1:0] ptr
);
        if (ptr == store_buf_pkg::SB_PTR_W'(store_buf_pkg::SB_DEPTH - 1))
                return '0;
        return ptr + 1'b1;
endfunction

// --------------------------------------------------
// Accept logic.
// --------------------------------------------------

always_comb begin
        full = (count == (store_buf_pkg::SB_PTR_W + 1)'(store_buf_pkg::SB_DEPTH));

        // No accept in the ack cycle, since the client still holds stb there.
        // One load in flight at most.
        enq  = i_req.cyc & i_req.stb & ~ack_q & ~rd_pend & ~full;
        deq  = o_pop.pop & o_pop.valid;
end

// Queue body, payload only.
always_ff @(posedge i_clk) begin
        if (enq) begin
                mem[wr_ptr].req   <= i_req.req;
                mem[wr_ptr].src_d <= i_req.src_d;
        end
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
                wr_ptr  <= '0;
                rd_ptr  <= '0;
                count   <= '0;
                ack_q   <= 1'b0;
                rd_pend <= 1'b0;
        end else begin
                if (enq)
                        wr_ptr <= ptr_inc(wr_ptr);
                if (deq)
                        rd_ptr <= ptr_inc(rd_ptr);

                case ({enq, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // Both or neither.
                endcase

                // Stores are posted. Loads ack after done.
                ack_q <= (enq & i_req.req.we) | o_pop.done;

                if (enq & ~i_req.req.we)
                        rd_pend <= 1'b1;           // Load queued.
                else if (o_pop.done)
                        rd_pend <= 1'b0;
        end
end

// Hold returned load data for the ack cycle.
always_ff @(posedge i_clk) begin
        if (o_pop.done)
                rdat_q <= o_pop.rdat;
end

// --------------------------------------------------
// Outputs.
// --------------------------------------------------

assign i_req.ack   = ack_q;
assign i_req.rdat  = rdat_q;
assign o_pop.valid = (count != '0);
assign o_pop.entry = mem[rd_ptr]; // Head entry.

endmodule

/* hdl/wb_merger.sv */
`timescale 1ns/10ps

module wb_merger (
        input  logic                          i_clk,
        input  logic                          i_rst_n,

        // --------------------------------------------------
        // Code client. Fetches only.
        // --------------------------------------------------

        input  logic                          i_c_wb_cyc,
        input  logic                          i_c_wb_stb,
        input  logic [wb_bus_pkg::ADDR_W-1:0] i_c_wb_adr,
        output logic                          o_c_wb_ack,
        output logic [wb_bus_pkg::DATA_W-1:0] o_c_wb_dat,

        // --------------------------------------------------
        // Data client. Loads and stores.
        // --------------------------------------------------

        input  logic                          i_d_wb_cyc,
        input  logic                          i_d_wb_stb,
        input  logic                          i_d_wb_we,
        input  logic [wb_bus_pkg::ADDR_W-1:0] i_d_wb_adr,
        input  logic [wb_bus_pkg::DATA_W-1:0] i_d_wb_dat,
        input  logic [wb_bus_pkg::SEL_W-1:0]  i_d_wb_sel,
        output logic                          o_d_wb_ack,
        output logic [wb_bus_pkg::DATA_W-1:0] o_d_wb_dat,

        // Merged stream.
        wb_req_if.master                      o_req
);

logic own_c; // Code client holds the grant.
logic own_d; // Data client holds the grant.

// Grant register. Data wins a tie while idle, and
// the owner keeps the bus until it drops cyc.
always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
                own_c <= 1'b0;
                own_d <= 1'b0;
        end else if (own_d) begin
                own_d <= i_d_wb_cyc;            // Release on cyc low.
        end else if (own_c) begin
                own_c <= i_c_wb_cyc;
        end else begin
                own_d <= i_d_wb_cyc;            // Data first.
                own_c <= i_c_wb_cyc & ~i_d_wb_cyc;
        end
end

// Request mux. Nothing goes out without a grant.
always_comb begin
        o_req.cyc   = 1'b0;
        o_req.stb   = 1'b0;
        o_req.src_d = own_d;
        o_req.req   = '0;

        if (own_d) begin
                o_req.cyc     = i_d_wb_cyc;
                o_req.stb     = i_d_wb_stb;
                o_req.req.we  = i_d_wb_we;
                o_req.req.adr = i_d_wb_adr;
                o_req.req.dat = i_d_wb_dat;
                o_req.req.sel = i_d_wb_sel;
        end else if (own_c) begin
                o_req.cyc     = i_c_wb_cyc;
                o_req.stb     = i_c_wb_stb;
                o_req.req.we  = 1'b0;                            // Fetch is a load.
                o_req.req.adr = {i_c_wb_adr[wb_bus_pkg::ADDR_W-1:2], 2'b00}; // Word aligned.
                o_req.req.sel = '1;                              // Full word.
        end
end

// Ack and load data back to the owner only.
assign o_d_wb_ack = own_d & o_req.ack;
assign o_c_wb_ack = own_c & o_req.ack;
assign o_d_wb_dat = own_d ? o_req.rdat : '0;
assign o_c_wb_dat = own_c ? o_req.rdat : '0;

endmodule

/* hdl/wb_if.sv */
`timescale 1ns/10ps

// --------------------------------------------------
// Merged request stream, merger to store buffer.
// --------------------------------------------------

interface wb_req_if;

        logic                          cyc;    // Owner cycle.
        logic                          stb;    // Request valid.
        logic                          src_d;  // Request came from the data client.
        wb_bus_pkg::wb_req_t           req;    // Held while stb is high, until ack.
        logic                          ack;    // One-cycle pulse.
        logic [wb_bus_pkg::DATA_W-1:0] rdat;   // Load data, valid with ack.

        modport master (
                output cyc, stb, src_d, req,
                input  ack, rdat
        );

        modport slave (
                input  cyc, stb, src_d, req,
                output ack, rdat
        );

endinterface

// --------------------------------------------------
// Head of the store buffer, buffer to bus master.
// --------------------------------------------------

interface sb_pop_if;

        logic                          valid;  // Buffer not empty.
        store_buf_pkg::sb_entry_t      entry;  // Head entry.
        logic                          pop;    // Dequeue head this cycle.
        logic                          done;   // External load finished.
        logic [wb_bus_pkg::DATA_W-1:0] rdat;   // Load data, valid with done.

        modport source (
                output valid, entry,
                input  pop, done, rdat
        );

        modport sink (
                input  valid, entry,
                output pop, done, rdat
        );

endinterface

/* hdl/store_buf_pkg.sv */
package store_buf_pkg;

        // --------------------------------------------------
        // Store buffer geometry.
        // --------------------------------------------------

        localparam int SB_DEPTH = 4;                  // Entries.
        localparam int SB_PTR_W = $clog2(SB_DEPTH);   // Index width.

        // One queued transfer.
        typedef struct packed {
                wb_bus_pkg::wb_req_t req;    // Request as merged.
                logic                src_d;  // Data client when set, code otherwise.
        } sb_entry_t;

endpackage

/* hdl/wb_bus_pkg.sv */
package wb_bus_pkg;

        // --------------------------------------------------
        // Bus widths.
        // --------------------------------------------------

        localparam int ADDR_W = 32;          // Byte address.
        localparam int DATA_W = 32;          // One bus word.
        localparam int SEL_W  = DATA_W / 8;  // One select per byte lane.

        // --------------------------------------------------
        // Request word.
        // --------------------------------------------------

        // Everything a client hands over for one transfer.
        // Handshake bits (cyc, stb) travel beside it.
        typedef struct packed {
                logic              we;   // Store when set.
                logic [ADDR_W-1:0] adr;  // Byte address.
                logic [DATA_W-1:0] dat;  // Store data, ignored on loads.
                logic [SEL_W-1:0]  sel;  // Byte enables.
        } wb_req_t;

endpackage
